//--- build.f
src/hc_pkg.sv
src/hc_payload_fifo.sv
src/hc_write_channel.sv
src/hc_status_mgr.sv
src/hc_ring_writer.sv
src/hc_top.sv
tb/hc_top_properties.sv
tb/hc_checker.sv
tb/tb_hc_top.sv

//--- run.sh
#!/bin/sh
# Builds the hc_top testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_hc_top -f build.f
status=$?
if [ $status -ne 0 ]; then
    echo "run.sh: Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_hc_top 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "run.sh: simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
    exit 0
fi
echo "run.sh: pass line not found in the simulation output"
exit 1

//--- tb/tb_hc_top.sv
// Six random-traffic tests of 400 cycles each; base_addr is fixed for the whole run
`timescale 1ns/100ps

module tb_hc_top;

    import hc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_PHASES = 6;
    localparam int PHASE_CYCLES = 400;
    // Traffic part of a test, the rest of its budget is left for draining
    localparam int TRAFFIC_CYCLES = 300;
    localparam int WATCHDOG_CYCLES = (PHASE_CYCLES * NUM_PHASES * 3) / 2;

    logic      clk;
    logic      reset_n;
    logic      hc_en;
    t_addr     base_addr;
    t_line     tx_data;
    logic      tx_enable;
    logic      tx_rdy;
    logic      host_consume;
    t_ring_idx host_oldest_idx;
    t_mem_req  mem_req;
    logic      mem_ack;
    t_ring_idx next_write_idx;

    // Test control, all driven on the rising edge
    int   phase;
    logic phase_end;
    logic tx_on;
    int   tx_pct;
    logic ack_hold;
    logic consume_on;
    logic drained;
    int   error_count;
    int   tests_failed;

    // Memory model state, a queue of acknowledge due cycles in request order
    int cycle;
    int ack_due[$];
    logic [31:0] rng_state;

    hc_top uut
    (
        .clk, .reset_n, .hc_en, .base_addr, .tx_data, .tx_enable, .tx_rdy,
        .host_consume, .host_oldest_idx, .mem_req, .mem_ack, .next_write_idx
    );

    hc_checker u_checker
    (
        .clk, .reset_n, .hc_en, .base_addr, .tx_data, .tx_enable, .tx_rdy,
        .host_oldest_idx, .mem_req, .mem_ack, .next_write_idx,
        .phase, .phase_end, .drained, .error_count, .tests_failed
    );

    bind hc_top hc_top_properties u_props
    (
        .clk(clk),
        .reset_n(reset_n),
        .mem_req(mem_req),
        .credits(u_write_channel.credits)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ============================================================
    // Random stimulus
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic roll_random(output logic [31:0] value);
        rng_state = xorshift32(rng_state);
        value = rng_state;
    endtask

    // Client, memory acknowledge and host consumer share one process and one random stream
    always @(posedge clk)
    begin
        logic [31:0] r_tx;
        logic [31:0] r_lo;
        logic [31:0] r_hi;
        logic [31:0] r_ack;
        logic [31:0] r_host;
        t_ring_idx avail;
        t_ring_idx step;

        roll_random(r_tx);
        roll_random(r_lo);
        roll_random(r_hi);
        roll_random(r_ack);
        roll_random(r_host);
        if (reset_n)
        begin
            cycle <= cycle + 1;
            tx_enable <= tx_on && tx_rdy && ((r_tx % 100) < tx_pct);
            tx_data <= {r_hi, r_lo};

            // Every write is acknowledged 1 to 6 cycles after it shows up
            if (mem_req.valid)
                ack_due.push_back(cycle + 1 + int'(r_ack % 6));
            mem_ack <= 1'b0;
            if (!ack_hold && (ack_due.size() > 0) && (ack_due[0] <= cycle))
            begin
                mem_ack <= 1'b1;
                ack_due.delete(0);
            end

            // The host frees up to four published entries, never two pulses in a row
            host_consume <= 1'b0;
            avail = next_write_idx - host_oldest_idx;
            step = t_ring_idx'(r_host[1:0]) + 1'b1;
            if (step > avail)
                step = avail;
            if (consume_on && !host_consume && (avail != '0) && !r_host[2])
            begin
                host_oldest_idx <= host_oldest_idx + step;
                host_consume <= 1'b1;
            end
        end
    end

    // ============================================================
    // Test sequence
    // ============================================================

    task automatic set_controls(input int p, input int c);
        tx_on <= 1'b1;
        tx_pct <= 70;
        hc_en <= 1'b1;
        ack_hold <= 1'b0;
        consume_on <= 1'b1;
        case (p)
            2: tx_pct <= 100;
            3:
            begin
                // Bursts of 30 cycles with long gaps for the idle counter
                tx_on <= ((c % 80) < 30);
                tx_pct <= 90;
            end
            4:
            begin
                tx_pct <= 80;
                consume_on <= (c >= 220);
            end
            5: hc_en <= !((c >= 60) && (c < 200));
            6:
            begin
                tx_pct <= 90;
                ack_hold <= (c >= 40) && (c < 160);
            end
            default: tx_pct <= 70;
        endcase
    endtask

    // Traffic, then a quiet drain until every line is written and published
    task automatic run_phase(input int p);
        phase <= p;
        for (int c = 0; c < TRAFFIC_CYCLES; c++)
        begin
            set_controls(p, c);
            @(posedge clk);
        end
        tx_on <= 1'b0;
        hc_en <= 1'b1;
        ack_hold <= 1'b0;
        consume_on <= 1'b1;
        repeat (2) @(posedge clk);
        while (!drained)
            @(posedge clk);
        phase_end <= 1'b1;
        @(posedge clk);
        phase_end <= 1'b0;
    endtask

    initial
    begin
        clk = 1'b0;
        reset_n = 1'b0;
        hc_en = 1'b0;
        base_addr = 16'h4a20;
        tx_data = '0;
        tx_enable = 1'b0;
        host_consume = 1'b0;
        host_oldest_idx = '0;
        mem_ack = 1'b0;
        phase = 0;
        phase_end = 1'b0;
        tx_on = 1'b0;
        tx_pct = 0;
        ack_hold = 1'b0;
        consume_on = 1'b0;
        cycle = 0;
        rng_state = 32'h8553;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        for (int p = 1; p <= NUM_PHASES; p++)
            run_phase(p);
        @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors", NUM_PHASES, tests_failed, error_count);
        if ((error_count == 0) && (tests_failed == 0))
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

    // Watchdog at one and a half times the total test budget
    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: test %0d did not drain within %0d cycles", phase, WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- tb/hc_checker.sv
// Reference model of the ring writer; samples everything on the rising edge before that edge's updates
`timescale 1ns/100ps

module hc_checker
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic              hc_en,
    input  hc_pkg::t_addr     base_addr,
    input  hc_pkg::t_line     tx_data,
    input  logic              tx_enable,
    input  logic              tx_rdy,
    input  hc_pkg::t_ring_idx host_oldest_idx,
    input  hc_pkg::t_mem_req  mem_req,
    input  logic              mem_ack,
    input  hc_pkg::t_ring_idx next_write_idx,
    input  int                phase,
    input  logic              phase_end,
    output logic              drained,
    output int                error_count,
    output int                tests_failed
);

    import hc_pkg::*;

    // Lines accepted from the client that have not reached mem_req yet
    t_line expected_lines[$];
    int unsigned lines_written;
    t_ring_idx model_published;
    int outstanding;
    logic crossed;
    int late_writes;
    logic hc_en_q;
    t_ring_idx published_q;
    int total_errors;
    int failed_tests;

    // Statistics of the running test
    int phase_errors;
    int phase_lines;
    int phase_fences;
    int phase_idle_fences;
    int max_fill;
    int max_outstanding;
    logic rdy_fell;

    // Values seen by the drain condition
    int pending_q;
    int outstanding_q;
    t_ring_idx written_q;

    // Everything accepted is written, acknowledged and published behind a fence
    assign drained = (pending_q == 0) && (outstanding_q == 0) && (next_write_idx == written_q);

    function automatic string phase_name(input int p);
        case (p)
            1: return "lines_in_order";
            2: return "quarter_fence";
            3: return "idle_fence";
            4: return "full_ring";
            5: return "disabled_channel";
            6: return "credit_backpressure";
            default: return "reset";
        endcase
    endfunction

    // Line writes land at the ring base plus their slot
    function automatic t_addr slot_addr(input t_ring_idx slot);
        return base_addr + t_addr'(slot);
    endfunction

    task automatic report_value(input string what, input logic [63:0] expected,
                                input logic [63:0] actual);
        $display("[FAIL] %s %s: expected %h, actual %h", phase_name(phase), what, expected, actual);
        total_errors++;
        phase_errors++;
    endtask

    task automatic report_text(input string msg);
        $display("[ERROR] %s: %s", phase_name(phase), msg);
        total_errors++;
        phase_errors++;
    endtask

    // Test-specific end checks followed by the result line of the test
    task automatic finish_phase();
        if ((phase == 3) && (phase_idle_fences == 0))
            report_text("no idle fence appeared after the client went quiet");
        if ((phase == 4) && (max_fill != (1 << RING_IDX_BITS) - 1))
            report_value("peak ring fill", 64'((1 << RING_IDX_BITS) - 1), 64'(max_fill));
        if ((phase == 4) && !rdy_fell)
            report_text("tx_rdy never fell after the ring filled up");
        if ((phase == 6) && (max_outstanding != WR_CREDITS))
            report_value("peak outstanding writes", 64'(WR_CREDITS), 64'(max_outstanding));
        if (phase_errors == 0)
            $display("test %0d %s passed: %0d lines, %0d fences", phase, phase_name(phase),
                     phase_lines, phase_fences);
        else
        begin
            $display("test %0d %s failed with %0d errors", phase, phase_name(phase), phase_errors);
            failed_tests++;
        end
        phase_errors = 0;
        phase_lines = 0;
        phase_fences = 0;
        phase_idle_fences = 0;
        max_fill = 0;
        max_outstanding = 0;
        rdy_fell = 1'b0;
    endtask

    always @(posedge clk)
    begin
        t_line exp_line;
        t_ring_idx slot;
        t_ring_idx fill;
        logic fence_seen;

        fence_seen = mem_req.valid && (mem_req.kind == REQ_FENCE);
        if (!reset_n)
        begin
            expected_lines.delete();
            lines_written = 0;
            model_published = '0;
            outstanding = 0;
            crossed = 1'b0;
            late_writes = 0;
            rdy_fell = 1'b0;
            hc_en_q <= 1'b0;
            published_q <= '0;
        end
        else
        begin
            if (tx_enable && tx_rdy)
                expected_lines.push_back(tx_data);
            // Back-pressure only counts once the ring has been seen full
            if (!tx_rdy && (max_fill == (1 << RING_IDX_BITS) - 1))
                rdy_fell = 1'b1;
            // A request needs hc_en at its grant one edge before it shows up
            if (mem_req.valid && !hc_en_q)
                report_text("memory request granted while hc_en was low");
            if (next_write_idx != published_q && !fence_seen)
                report_text("published index changed without a fence");

            if (mem_req.valid && (mem_req.kind == REQ_WRLINE))
            begin
                slot = t_ring_idx'(lines_written);
                if (expected_lines.size() == 0)
                    report_text("line write with no accepted line left to write");
                else
                begin
                    exp_line = expected_lines.pop_front();
                    if (mem_req.data != exp_line)
                        report_value("line data", exp_line, mem_req.data);
                end
                if (mem_req.addr != slot_addr(slot))
                    report_value("line address", 64'(slot_addr(slot)), 64'(mem_req.addr));
                if (t_ring_idx'(slot + 1'b1) == host_oldest_idx)
                    report_text("line write into the slot just before the host's oldest index");
                fill = slot + 1'b1 - host_oldest_idx;
                if (int'(fill) > max_fill)
                    max_fill = int'(fill);
                // After the quarter crossing only the write granted alongside it may pass
                if (crossed)
                begin
                    late_writes++;
                    if (late_writes > 1)
                        report_text("line write went out past a quarter crossing before its fence");
                end
                lines_written++;
                phase_lines++;
                slot = t_ring_idx'(lines_written);
                if (slot[RING_IDX_BITS-2] != model_published[RING_IDX_BITS-2])
                    crossed = 1'b1;
            end

            // The published index moves at the same edge that registers the fence
            if (fence_seen)
            begin
                if (next_write_idx != t_ring_idx'(lines_written))
                    report_value("published index", 64'(lines_written % 64), 64'(next_write_idx));
                // With no quarter crossing pending only the idle counter can raise a fence
                if (!crossed)
                    phase_idle_fences++;
                model_published = t_ring_idx'(lines_written);
                crossed = 1'b0;
                late_writes = 0;
                phase_fences++;
            end

            outstanding = outstanding + int'(mem_req.valid) - int'(mem_ack);
            if (outstanding > WR_CREDITS)
                report_value("outstanding writes", 64'(WR_CREDITS), 64'(outstanding));
            if (outstanding < 0)
                report_text("mem_ack with no write outstanding");
            if (outstanding > max_outstanding)
                max_outstanding = outstanding;
            if (phase_end)
                finish_phase();
            hc_en_q <= hc_en;
            published_q <= next_write_idx;
        end
        pending_q <= expected_lines.size();
        outstanding_q <= outstanding;
        written_q <= t_ring_idx'(lines_written);
        error_count <= total_errors;
        tests_failed <= failed_tests;
    end

    initial
    begin
        total_errors = 0;
        failed_tests = 0;
        phase_errors = 0;
        phase_lines = 0;
        phase_fences = 0;
        phase_idle_fences = 0;
        max_fill = 0;
        max_outstanding = 0;
    end

endmodule

//--- tb/hc_top_properties.sv
// Bound into hc_top; reads the write channel credit register through a hierarchical port connection
`timescale 1ns/100ps

module hc_top_properties
(
    input logic             clk,
    input logic             reset_n,
    input hc_pkg::t_mem_req mem_req,
    input hc_pkg::t_credit  credits
);

    import hc_pkg::*;

    // ============================================================
    // Credits
    // ============================================================

    // The channel can never hold more credits than writes it may have in flight
    a_credit_limit: assert property (@(posedge clk) disable iff (!reset_n)
        credits <= t_credit'(WR_CREDITS))
        else $error("write credit count %0d is above the limit", credits);

    // Reset refills the credit pool
    a_reset_credits: assert property (@(posedge clk) !reset_n |=> credits == t_credit'(WR_CREDITS))
        else $error("credit count not refilled by reset");

    // ============================================================
    // Memory requests
    // ============================================================

    // No memory request may leave the channel in the cycle after a reset cycle
    a_reset_idle: assert property (@(posedge clk) !reset_n |=> !mem_req.valid)
        else $error("memory request valid right after reset");

    // A fence carries no address of its own
    a_fence_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_req.valid && (mem_req.kind == REQ_FENCE)) |-> (mem_req.addr == t_addr'(0)))
        else $error("fence request with nonzero address %h", mem_req.addr);

endmodule

//--- src/hc_top.sv
// Host-bound channel top; the client must hold tx_enable low while tx_rdy is low
`timescale 1ns/100ps

module hc_top
(
    input  logic              clk,
    input  logic              reset_n,

    // Static configuration
    input  logic              hc_en,
    input  hc_pkg::t_addr     base_addr,

    // Client lines
    input  hc_pkg::t_line     tx_data,
    input  logic              tx_enable,
    output logic              tx_rdy,

    // Host consume updates
    input  logic              host_consume,
    input  hc_pkg::t_ring_idx host_oldest_idx,

    // Memory side
    output hc_pkg::t_mem_req  mem_req,
    input  logic              mem_ack,

    output hc_pkg::t_ring_idx next_write_idx
);

    import hc_pkg::*;

    t_line     line_data;
    logic      line_valid;
    logic      line_deq;
    t_ring_idx oldest_idx;
    t_wr_req   wr_req;
    t_wr_grant wr_grant;

    // Client lines wait here until the ring writer gets a grant
    hc_payload_fifo
    #(
        .payload_t(t_line)
    )
    u_line_fifo
    (
        .clk,
        .reset_n,
        .enq_data(tx_data),
        .enq_en(tx_enable && tx_rdy),
        .not_full(tx_rdy),
        .first(line_data),
        .deq_en(line_deq),
        .not_empty(line_valid)
    );

    hc_write_channel u_write_channel
    (
        .clk,
        .reset_n,
        .wr_req,
        .wr_grant,
        .mem_req,
        .mem_ack
    );

    hc_status_mgr u_status_mgr
    (
        .clk,
        .reset_n,
        .host_consume,
        .host_oldest_idx,
        .oldest_idx
    );

    hc_ring_writer u_ring_writer
    (
        .clk,
        .reset_n,
        .hc_en,
        .base_addr,
        .line_data,
        .line_valid,
        .line_deq,
        .oldest_idx,
        .wr_req,
        .wr_grant,
        .next_write_idx
    );

endmodule

//--- src/hc_ring_writer.sv
// Ring buffer writer; new entries reach next_write_idx only behind a fence, base_addr must stay stable
`timescale 1ns/100ps

module hc_ring_writer
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              hc_en,
    input  hc_pkg::t_addr     base_addr,

    input  hc_pkg::t_line     line_data,
    input  logic              line_valid,
    output logic              line_deq,

    input  hc_pkg::t_ring_idx oldest_idx,

    output hc_pkg::t_wr_req   wr_req,
    input  hc_pkg::t_wr_grant wr_grant,

    output hc_pkg::t_ring_idx next_write_idx
);

    import hc_pkg::*;

    // ========================================================
    // Ring pointers
    // ========================================================

    // Slot the next line write goes to
    t_ring_idx cur_idx;

    // Slots before this one are written and protected by a fence
    // It is the index the host sees
    t_ring_idx written_idx;

    assign next_write_idx = written_idx;

    // A quarter of the ring has been written since the last fence
    logic flush_for_writes;
    assign flush_for_writes = (cur_idx[RING_IDX_BITS-2] != written_idx[RING_IDX_BITS-2]);

    // One slot always stays empty so a full ring differs from an empty one
    logic allow_write;
    assign allow_write = ((cur_idx + t_ring_idx'(1)) != oldest_idx);

    // ========================================================
    // State machine
    // ========================================================

    typedef enum logic [1:0]
    {
        WAIT_EMPTY,
        WAIT_DATA,
        EMIT_FENCE
    } t_state;

    t_state state;

    // A grant outside the fence state is always a line write
    assign line_deq = wr_grant.writer_grant && (state != EMIT_FENCE);

    // Idle flush logic
    logic [IDLE_CNT_BITS-1:0] idle_cycles;
    logic flush_for_idle;

    // The move to EMIT_FENCE keeps the idle request alive until the fence is granted
    assign flush_for_idle = idle_cycles[IDLE_CNT_BITS-1];

    // Idle cycles only count while the channel could have taken a line
    // so that a saturated memory bus does not trigger extra fences
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            idle_cycles <= '0;
        end
        else if ((state != WAIT_DATA) || line_deq)
        begin
            idle_cycles <= '0;
        end
        else if (wr_grant.can_issue)
        begin
            idle_cycles <= idle_cycles + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            state <= WAIT_EMPTY;
            cur_idx <= t_ring_idx'(0);
            written_idx <= t_ring_idx'(0);
        end
        else
        begin
            case (state)
                WAIT_EMPTY:
                begin
                    // Nothing unpublished yet, so no fence is needed until a write
                    if (wr_grant.writer_grant)
                    begin
                        state <= WAIT_DATA;
                        cur_idx <= cur_idx + t_ring_idx'(1);
                    end
                end

                WAIT_DATA:
                begin
                    if (wr_grant.writer_grant)
                    begin
                        cur_idx <= cur_idx + t_ring_idx'(1);
                    end

                    // A write granted in this same cycle is covered by the fence too
                    if (flush_for_idle || flush_for_writes)
                    begin
                        state <= EMIT_FENCE;
                    end
                end

                EMIT_FENCE:
                begin
                    // Everything up to cur_idx is now ordered ahead of the fence
                    if (wr_grant.writer_grant)
                    begin
                        state <= WAIT_EMPTY;
                        written_idx <= cur_idx;
                    end
                end

                default:
                begin
                    state <= WAIT_EMPTY;
                end
            endcase
        end
    end

    // ========================================================
    // Request building
    // ========================================================

    // Fences wait only for the enable while line writes also need ring space
    always_comb
    begin
        wr_req.data = line_data;

        if (state == EMIT_FENCE)
        begin
            wr_req.request = hc_en;
            wr_req.kind = REQ_FENCE;
            wr_req.addr = t_addr'(0);
        end
        else
        begin
            wr_req.request = hc_en && allow_write && line_valid;
            wr_req.kind = REQ_WRLINE;
            wr_req.addr = base_addr + t_addr'(cur_idx);
        end
    end

endmodule

//--- src/hc_status_mgr.sv
// Tracks the host's oldest live slot; a consume pulse arriving while two updates wait is dropped
`timescale 1ns/100ps

module hc_status_mgr
(
    input  logic              clk,
    input  logic              reset_n,

    input  logic              host_consume,
    input  hc_pkg::t_ring_idx host_oldest_idx,

    output hc_pkg::t_ring_idx oldest_idx
);

    import hc_pkg::*;

    // Queue of pending consume updates
    t_ring_idx update_idx;
    logic update_valid;
    logic update_room;

    // Two back-to-back pulses fit in the queue while the first one drains
    hc_payload_fifo
    #(
        .payload_t(t_ring_idx)
    )
    u_update_fifo
    (
        .clk,
        .reset_n,
        .enq_data(host_oldest_idx),
        .enq_en(host_consume && update_room),
        .not_full(update_room),
        .first(update_idx),
        .deq_en(update_valid),
        .not_empty(update_valid)
    );

    // ========================================================
    // Oldest live index
    // ========================================================

    // One update is applied per cycle, two cycles after its pulse
    // The ring writer compares against this to tell when the ring is full
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_idx <= t_ring_idx'(0);
        end
        else if (update_valid)
        begin
            oldest_idx <= update_idx;
        end
    end

endmodule

//--- src/hc_write_channel.sv
// Credit-limited write channel; each mem_ack pulse must answer exactly one earlier mem_req.valid
`timescale 1ns/100ps

module hc_write_channel
(
    input  logic              clk,
    input  logic              reset_n,

    input  hc_pkg::t_wr_req   wr_req,
    output hc_pkg::t_wr_grant wr_grant,

    output hc_pkg::t_mem_req  mem_req,
    input  logic              mem_ack
);

    import hc_pkg::*;

    // Number of writes that may still be sent before an acknowledge
    t_credit credits;

    logic grant;

    // Registered copy of the granted request
    logic      mem_valid;
    t_req_kind mem_kind;
    t_addr     mem_addr;
    t_line     mem_data;

    // ========================================================
    // Grant
    // ========================================================

    // The grant is combinational so the writer can dequeue in the same cycle
    assign grant = wr_req.request && (credits != t_credit'(0));

    assign wr_grant.can_issue = (credits != t_credit'(0));
    assign wr_grant.writer_grant = grant;

    // A grant spends a credit and an acknowledge returns one, possibly both at once
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            credits <= t_credit'(WR_CREDITS);
            mem_valid <= 1'b0;
        end
        else
        begin
            credits <= credits - t_credit'(grant) + t_credit'(mem_ack);
            mem_valid <= grant;
        end
    end

    // ========================================================
    // Memory request register
    // ========================================================

    // Payload is only captured on a grant and needs no reset
    always_ff @(posedge clk)
    begin
        if (grant)
        begin
            mem_kind <= wr_req.kind;
            mem_addr <= wr_req.addr;
            mem_data <= wr_req.data;
        end
    end

    assign mem_req = '{valid: mem_valid, kind: mem_kind, addr: mem_addr, data: mem_data};

endmodule

//--- src/hc_payload_fifo.sv
// Two-entry FIFO; enq_en must stay low while not_full is low and deq_en low while not_empty is low
`timescale 1ns/100ps

module hc_payload_fifo
#(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     reset_n,

    input  payload_t enq_data,
    input  logic     enq_en,
    output logic     not_full,

    output payload_t first,
    input  logic     deq_en,
    output logic     not_empty
);

    // Entry 0 is always the head, entry 1 holds the one behind it
    payload_t entry_data [2];
    logic [1:0] entry_valid;

    // Occupancy once this cycle's dequeue has shifted the entries
    logic keep0_valid;
    logic keep1_valid;

    assign keep0_valid = deq_en ? entry_valid[1] : entry_valid[0];
    assign keep1_valid = deq_en ? 1'b0 : entry_valid[1];

    assign first = entry_data[0];
    assign not_empty = entry_valid[0];
    assign not_full = !entry_valid[1];

    // Valid bits are control state and clear on reset
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            entry_valid <= 2'b00;
        end
        else
        begin
            // A new entry lands in the first slot left free after the shift
            entry_valid[0] <= keep0_valid || enq_en;
            entry_valid[1] <= keep1_valid || (enq_en && keep0_valid);
        end
    end

    // Payload moves toward the head on a dequeue
    always_ff @(posedge clk)
    begin
        if (deq_en)
        begin
            entry_data[0] <= entry_data[1];
        end

        // The enqueue is written last so it wins over the shift into slot 0
        if (enq_en && !keep0_valid)
        begin
            entry_data[0] <= enq_data;
        end
        else if (enq_en)
        begin
            entry_data[1] <= enq_data;
        end
    end

endmodule

//--- src/hc_pkg.sv
// Shared ring, line, request and credit types; the ring must stay a power of two and at least 8
package hc_pkg;

    // ========================================================
    // Sizes
    // ========================================================

    // Width of one client data line
    localparam int LINE_BITS = 64;

    // Width of a ring index, which sets the number of ring slots
    localparam int RING_IDX_BITS = 6;

    // The top bit of the idle counter marks sixteen idle cycles
    localparam int IDLE_CNT_BITS = 5;

    // Maximum number of memory writes in flight
    localparam int WR_CREDITS = 4;

    // Wide enough to hold every value from zero up to WR_CREDITS
    localparam int CREDIT_BITS = $clog2(WR_CREDITS + 1);

    // ========================================================
    // Types
    // ========================================================

    typedef logic [LINE_BITS-1:0] t_line;
    typedef logic [RING_IDX_BITS-1:0] t_ring_idx;
    typedef logic [15:0] t_addr;
    typedef logic [CREDIT_BITS-1:0] t_credit;

    // A line write, or a fence that orders all earlier writes
    typedef enum logic
    {
        REQ_WRLINE,
        REQ_FENCE
    } t_req_kind;

    // Request as it leaves the write channel toward memory
    typedef struct packed
    {
        logic valid;
        t_req_kind kind;
        t_addr addr;
        t_line data;
    } t_mem_req;

    // Request from the ring writer, still waiting for a grant
    typedef struct packed
    {
        logic request;
        t_req_kind kind;
        t_addr addr;
        t_line data;
    } t_wr_req;

    // Grant from the write channel back to the ring writer
    typedef struct packed
    {
        logic writer_grant;
        logic can_issue;
    } t_wr_grant;

endpackage
